//--- Bender.yml
package:
  name: hud_display

sources:
  - files:
      - design/hud_pkg.sv
      - design/glyph_pkg.sv
      - design/raster_counter.sv
      - design/glyph_rom.sv
      - design/num_display.sv
      - design/hud_mixer.sv
      - design/hud_display.sv
  - target: test
    files:
      - test/tb_hud_display.sv

//--- design/glyph_pkg.sv
package glyph_pkg;

    typedef logic [3:0] digit_t;       // one bcd nibble.
    typedef logic [8:0] glyph_addr_t;  // bit address into the font rom.

    localparam int GLYPH_W     = 5;  // columns per glyph.
    localparam int GLYPH_H     = 7;  // lines per glyph.
    localparam int GLYPH_SIZE  = GLYPH_W * GLYPH_H;
    localparam int GLYPH_COUNT = 10; // digits 0 to 9 only.

    // Distance between the left columns of neighbouring digits.
    // One blank column separates two glyphs.
    localparam int DIGIT_PITCH = 6;

    // total number of font bits held by the rom.
    localparam int GLYPH_ROM_DEPTH = GLYPH_COUNT * GLYPH_SIZE;

    // one glyph line, leftmost pixel in the most significant bit.
    typedef logic [GLYPH_W-1:0] glyph_row_t;

    // The rom is addressed as
    //   col + row * GLYPH_W + digit * GLYPH_SIZE
    // so each glyph occupies a contiguous, row-major block of bits.
    // A valid address never reaches GLYPH_ROM_DEPTH.

endpackage

//--- design/glyph_rom.sv
`timescale 1ns/1ns

module glyph_rom import glyph_pkg::*; (
    input  logic        pixel_clk_in,
    input  glyph_addr_t addr,
    output logic        bit_out
);

    // 5x7 digit shapes, seven lines per digit.
    localparam glyph_row_t FONT_ROWS [GLYPH_COUNT * GLYPH_H] = '{
        5'b01110, 5'b10001, 5'b10011, 5'b10101, 5'b11001, 5'b10001, 5'b01110,
        5'b00100, 5'b01100, 5'b00100, 5'b00100, 5'b00100, 5'b00100, 5'b01110,
        5'b01110, 5'b10001, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b11111,
        5'b11111, 5'b00010, 5'b00100, 5'b00010, 5'b00001, 5'b10001, 5'b01110,
        5'b00010, 5'b00110, 5'b01010, 5'b10010, 5'b11111, 5'b00010, 5'b00010,
        5'b11111, 5'b10000, 5'b11110, 5'b00001, 5'b00001, 5'b10001, 5'b01110,
        5'b00110, 5'b01000, 5'b10000, 5'b11110, 5'b10001, 5'b10001, 5'b01110,
        5'b11111, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b01000, 5'b01000,
        5'b01110, 5'b10001, 5'b10001, 5'b01110, 5'b10001, 5'b10001, 5'b01110,
        5'b01110, 5'b10001, 5'b10001, 5'b01111, 5'b00001, 5'b00010, 5'b01100
    };

    // flatten the rows into one bit per address.
    function automatic logic [GLYPH_ROM_DEPTH-1:0] build_font();
        logic [GLYPH_ROM_DEPTH-1:0] bits;
        bits = '0;
        for (int d = 0; d < GLYPH_COUNT; d++) begin
            for (int r = 0; r < GLYPH_H; r++) begin
                for (int c = 0; c < GLYPH_W; c++) begin
                    bits[d * GLYPH_SIZE + r * GLYPH_W + c] =
                        FONT_ROWS[d * GLYPH_H + r][GLYPH_W - 1 - c];
                end
            end
        end
        return bits;
    endfunction

    localparam logic [GLYPH_ROM_DEPTH-1:0] FONT = build_font();

    always_ff @(posedge pixel_clk_in) begin
        bit_out <= FONT[addr];  // one cycle read latency.
    end

    // the renderer parks the address at zero outside digit cells.
    a_addr_range: assert property (
        @(posedge pixel_clk_in)
        !$isunknown(addr) |-> addr < glyph_addr_t'(GLYPH_ROM_DEPTH)
    ) else $error("font address %0d is past the last glyph", addr);

endmodule

//--- design/hud_display.sv
`timescale 1ns/1ns

module hud_display import hud_pkg::*; #(
    parameter int H_ACTIVE     = 640,
    parameter int H_TOTAL      = 800,
    parameter int H_SYNC_START = 656,
    parameter int H_SYNC_END   = 752,
    parameter int V_ACTIVE     = 480,
    parameter int V_TOTAL      = 525,
    parameter int V_SYNC_START = 490,
    parameter int V_SYNC_END   = 492
) (
    input  logic    pixel_clk_in,
    input  logic    reset,
    input  bcd3_t   time_left,
    input  bcd3_t   point_total,
    output rgb12_t  pixel,
    output logic    hsync_out,
    output logic    vsync_out,
    output hcount_t hcount_out,
    output vcount_t vcount_out
);

    hcount_t hcount;
    vcount_t vcount;
    logic    active;
    logic    hsync;
    logic    vsync;
    logic    glyph_on;  // two cycles behind the raster state.

    raster_counter #(
        .H_ACTIVE    (H_ACTIVE),
        .H_TOTAL     (H_TOTAL),
        .H_SYNC_START(H_SYNC_START),
        .H_SYNC_END  (H_SYNC_END),
        .V_ACTIVE    (V_ACTIVE),
        .V_TOTAL     (V_TOTAL),
        .V_SYNC_START(V_SYNC_START),
        .V_SYNC_END  (V_SYNC_END)
    ) raster_counter_i (
        .pixel_clk_in(pixel_clk_in),
        .reset       (reset),
        .hcount      (hcount),
        .vcount      (vcount),
        .active      (active),
        .hsync       (hsync),
        .vsync       (vsync)
    );

    num_display #(
        .V_ACTIVE(V_ACTIVE)
    ) num_display_i (
        .pixel_clk_in(pixel_clk_in),
        .reset       (reset),
        .time_left   (time_left),
        .point_total (point_total),
        .hcount      (hcount),
        .vcount      (vcount),
        .glyph_on    (glyph_on)
    );

    hud_mixer hud_mixer_i (
        .pixel_clk_in(pixel_clk_in),
        .reset       (reset),
        .hcount      (hcount),
        .vcount      (vcount),
        .active      (active),
        .hsync       (hsync),
        .vsync       (vsync),
        .glyph_on    (glyph_on),
        .pixel       (pixel),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .hcount_out  (hcount_out),
        .vcount_out  (vcount_out)
    );

endmodule

//--- design/hud_mixer.sv
`timescale 1ns/1ns

module hud_mixer import hud_pkg::*; (
    input  logic    pixel_clk_in,
    input  logic    reset,
    input  hcount_t hcount,
    input  vcount_t vcount,
    input  logic    active,
    input  logic    hsync,
    input  logic    vsync,
    input  logic    glyph_on,
    output rgb12_t  pixel,
    output logic    hsync_out,
    output logic    vsync_out,
    output hcount_t hcount_out,
    output vcount_t vcount_out
);

    hcount_t hcount_d1;
    hcount_t hcount_d2;
    vcount_t vcount_d1;
    vcount_t vcount_d2;
    logic    active_d1;
    logic    active_d2;
    logic    hsync_d1;
    logic    hsync_d2;
    logic    vsync_d1;
    logic    vsync_d2;
    rgb12_t  pixel_next;

    function automatic logic in_box(hcount_t x, vcount_t y, hcount_t box_x, vcount_t box_y);
        return (x >= box_x) && (x < box_x + BOX_SIZE) &&
               (y >= box_y) && (y < box_y + vcount_t'(BOX_SIZE));
    endfunction

    // two stages match the renderer latency.
    always_ff @(posedge pixel_clk_in) begin
        if (reset) begin
            hcount_d1 <= '0;
            hcount_d2 <= '0;
            vcount_d1 <= '0;
            vcount_d2 <= '0;
            active_d1 <= 1'b0;
            active_d2 <= 1'b0;
            hsync_d1  <= 1'b0;
            hsync_d2  <= 1'b0;
            vsync_d1  <= 1'b0;
            vsync_d2  <= 1'b0;
        end else begin
            hcount_d1 <= hcount;
            hcount_d2 <= hcount_d1;
            vcount_d1 <= vcount;
            vcount_d2 <= vcount_d1;
            active_d1 <= active;
            active_d2 <= active_d1;
            hsync_d1  <= hsync;
            hsync_d2  <= hsync_d1;
            vsync_d1  <= vsync;
            vsync_d2  <= vsync_d1;
        end
    end

    always_comb begin
        if (!active_d2) begin
            pixel_next = BG_COLOUR;
        end else if (glyph_on) begin
            pixel_next = DIGIT_COLOUR;
        end else if (in_box(hcount_d2, vcount_d2, TIME_BOX_X, TIME_BOX_Y)) begin
            pixel_next = TIME_BOX_COLOUR;
        end else if (in_box(hcount_d2, vcount_d2, POINTS_BOX_X, POINTS_BOX_Y)) begin
            pixel_next = POINTS_BOX_COLOUR;
        end else begin
            pixel_next = BG_COLOUR;
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        if (reset) begin
            pixel      <= BG_COLOUR;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hcount_out <= '0;
            vcount_out <= '0;
        end else begin
            pixel      <= pixel_next;
            hsync_out  <= hsync_d2;
            vsync_out  <= vsync_d2;
            hcount_out <= hcount_d2;  // tags the pixel with its position.
            vcount_out <= vcount_d2;
        end
    end

    a_blank_is_bg: assert property (
        @(posedge pixel_clk_in) disable iff (reset)
        !active_d2 |=> pixel == BG_COLOUR
    ) else $error("pixel %h drawn during blanking", pixel);

endmodule

//--- design/hud_pkg.sv
package hud_pkg;

    typedef logic [10:0] hcount_t;  // horizontal pixel position.
    typedef logic [9:0]  vcount_t;  // line number.
    typedef logic [11:0] rgb12_t;   // four bits each of red, green, blue.
    typedef logic [11:0] bcd3_t;    // three bcd digits, most significant first.

    // left column of each digit cell, hundreds digit first.
    localparam hcount_t TIME_COL_2   = 11'd57;
    localparam hcount_t TIME_COL_1   = 11'd63;
    localparam hcount_t TIME_COL_0   = 11'd69;
    localparam hcount_t POINTS_COL_2 = 11'd582;
    localparam hcount_t POINTS_COL_1 = 11'd588;
    localparam hcount_t POINTS_COL_0 = 11'd594;
    localparam vcount_t DIGIT_ROW    = 10'd427;  // top line of all six cells.

    // badge boxes sit behind the digits.
    localparam hcount_t TIME_BOX_X   = 11'd50;
    localparam vcount_t TIME_BOX_Y   = 10'd415;
    localparam hcount_t POINTS_BOX_X = 11'd575;
    localparam vcount_t POINTS_BOX_Y = 10'd415;
    localparam hcount_t BOX_SIZE     = 11'd32;   // boxes are square.

    localparam rgb12_t DIGIT_COLOUR      = 12'hFFF;
    localparam rgb12_t TIME_BOX_COLOUR   = 12'hFF0;
    localparam rgb12_t POINTS_BOX_COLOUR = 12'h00F;
    localparam rgb12_t BG_COLOUR         = 12'h000;

endpackage

//--- design/num_display.sv
`timescale 1ns/1ns

module num_display import hud_pkg::*, glyph_pkg::*; #(
    parameter int V_ACTIVE = 480
) (
    input  logic    pixel_clk_in,
    input  logic    reset,
    input  bcd3_t   time_left,
    input  bcd3_t   point_total,
    input  hcount_t hcount,
    input  vcount_t vcount,
    output logic    glyph_on
);

    localparam int CELLS = 6;

    localparam hcount_t CELL_X [CELLS] = '{
        TIME_COL_2, TIME_COL_1, TIME_COL_0,
        POINTS_COL_2, POINTS_COL_1, POINTS_COL_0
    };

    bcd3_t            time_shadow;
    bcd3_t            point_shadow;
    digit_t           cell_digit [CELLS];
    logic [CELLS-1:0] cell_hit;
    logic             row_hit;
    logic             in_cell;
    glyph_addr_t      addr_next;
    glyph_addr_t      addr_q;
    logic             cell_q;
    logic             cell_d2;
    logic             rom_bit;

    // Neighbouring cells must sit exactly one pitch apart.
    // That spacing keeps the six cells disjoint.
    if ((TIME_COL_1 - TIME_COL_2 != DIGIT_PITCH) || (TIME_COL_0 - TIME_COL_1 != DIGIT_PITCH) ||
        (POINTS_COL_1 - POINTS_COL_2 != DIGIT_PITCH) ||
        (POINTS_COL_0 - POINTS_COL_1 != DIGIT_PITCH)) begin : g_pitch_check
        $error("digit columns do not follow the digit pitch");
    end

    // counters change only at the start of vertical blanking, so no frame tears.
    always_ff @(posedge pixel_clk_in) begin
        if (reset) begin
            time_shadow  <= '0;
            point_shadow <= '0;
        end else if (hcount == '0 && vcount == vcount_t'(V_ACTIVE)) begin
            time_shadow  <= time_left;
            point_shadow <= point_total;
        end
    end

    assign cell_digit = '{
        time_shadow[11:8], time_shadow[7:4], time_shadow[3:0],
        point_shadow[11:8], point_shadow[7:4], point_shadow[3:0]
    };

    assign row_hit = (vcount >= DIGIT_ROW) && (vcount < DIGIT_ROW + vcount_t'(GLYPH_H));

    always_comb begin
        int col_off;
        int row_off;
        int digit;
        col_off = 0;
        row_off = int'(vcount - DIGIT_ROW);
        digit   = 0;
        for (int i = 0; i < CELLS; i++) begin
            cell_hit[i] = row_hit && (hcount >= CELL_X[i]) &&
                          (hcount < CELL_X[i] + hcount_t'(GLYPH_W));
            if (cell_hit[i]) begin
                col_off = int'(hcount - CELL_X[i]);
                digit   = int'(cell_digit[i]);
            end
        end
        in_cell = (|cell_hit) && (digit < GLYPH_COUNT);  // nibbles above 9 stay blank.
        if (in_cell) begin
            addr_next = glyph_addr_t'(col_off + row_off * GLYPH_W + digit * GLYPH_SIZE);
        end else begin
            addr_next = '0;
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        if (reset) begin
            addr_q  <= '0;
            cell_q  <= 1'b0;
            cell_d2 <= 1'b0;
        end else begin
            addr_q  <= addr_next;
            cell_q  <= in_cell;
            cell_d2 <= cell_q;  // lines up with the rom output register.
        end
    end

    glyph_rom glyph_rom_i (
        .pixel_clk_in(pixel_clk_in),
        .addr        (addr_q),
        .bit_out     (rom_bit)
    );

    assign glyph_on = rom_bit & cell_d2;

    a_one_cell: assert property (
        @(posedge pixel_clk_in) disable iff (reset)
        $onehot0(cell_hit)
    ) else $error("beam at %0d,%0d falls in two digit cells", hcount, vcount);

endmodule

//--- design/raster_counter.sv
`timescale 1ns/1ns

module raster_counter import hud_pkg::*; #(
    parameter int H_ACTIVE     = 640,
    parameter int H_TOTAL      = 800,
    parameter int H_SYNC_START = 656,
    parameter int H_SYNC_END   = 752,
    parameter int V_ACTIVE     = 480,
    parameter int V_TOTAL      = 525,
    parameter int V_SYNC_START = 490,
    parameter int V_SYNC_END   = 492
) (
    input  logic    pixel_clk_in,
    input  logic    reset,
    output hcount_t hcount,
    output vcount_t vcount,
    output logic    active,
    output logic    hsync,
    output logic    vsync
);

    hcount_t h_next;
    vcount_t v_next;

    // next beam position, so that every flag is registered with the counters.
    always_comb begin
        if (hcount == hcount_t'(H_TOTAL - 1)) begin
            h_next = '0;
            if (vcount == vcount_t'(V_TOTAL - 1)) begin
                v_next = '0;
            end else begin
                v_next = vcount + 1'b1;
            end
        end else begin
            h_next = hcount + 1'b1;
            v_next = vcount;
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
            active <= 1'b0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
        end else begin
            hcount <= h_next;
            vcount <= v_next;
            active <= (h_next < hcount_t'(H_ACTIVE)) && (v_next < vcount_t'(V_ACTIVE));
            hsync  <= (h_next >= hcount_t'(H_SYNC_START)) &&
                      (h_next < hcount_t'(H_SYNC_END));    // one pulse per line.
            vsync  <= (v_next >= vcount_t'(V_SYNC_START)) &&
                      (v_next < vcount_t'(V_SYNC_END));    // whole lines.
        end
    end

    a_hcount_range: assert property (
        @(posedge pixel_clk_in) disable iff (reset)
        hcount < hcount_t'(H_TOTAL)
    ) else $error("hcount %0d ran past the line length", hcount);

endmodule

//--- hud_display.f
design/hud_pkg.sv
design/glyph_pkg.sv
design/raster_counter.sv
design/glyph_rom.sv
design/num_display.sv
design/hud_mixer.sv
design/hud_display.sv
test/tb_hud_display.sv

//--- test/hud_golden.txt
# F <time_left hex> <point_total hex> : counters applied at line 100, shown from the next frame
# S <hcount dec> <vcount dec> <pixel hex> : expected pixel at that output position
F 123 456
S 300 200 000
S 50 415 FF0
S 606 415 00F
S 57 427 FF0
S 58 427 FFF
S 582 430 FFF
S 607 446 000
F 9A0 0B7
S 58 427 FF0
S 59 427 FFF
S 63 428 FFF
S 62 430 FF0
S 586 431 FFF
S 589 432 00F
S 595 433 FFF
F 807 999
S 64 427 FF0
S 589 427 00F
S 594 427 FFF
S 57 428 FFF
S 598 428 FFF
S 65 433 FF0
F 555 555
S 57 427 FF0
S 58 427 FFF
S 63 430 FFF
S 64 430 FF0
S 585 430 FFF
S 70 431 FFF

//--- test/tb_hud_display.sv
`timescale 1ns/1ns

module tb_hud_display import hud_pkg::*; ();

    localparam int CLK_HALF     = 10;
    localparam int RESET_CYCLES = 8;
    localparam int OUT_LATENCY  = 3;
    localparam int H_TOTAL      = 800;
    localparam int V_TOTAL      = 525;
    localparam int HSYNC_WIDTH  = 96;
    localparam int APPLY_LINE   = 100;  // well inside active video.
    localparam int FILLER_LINE  = 481;  // first whole line after the frame latch.

    logic    pixel_clk_in;
    logic    reset;
    bcd3_t   time_left;
    bcd3_t   point_total;
    rgb12_t  pixel;
    logic    hsync_out;
    logic    vsync_out;
    hcount_t hcount_out;
    vcount_t vcount_out;

    bit      rec_is_frame [$];
    int      rec_a [$];
    int      rec_b [$];
    int      rec_c [$];
    longint  budget_cycles = 0;
    int      errors = 0;
    int      applied = 0;

    hud_display dut_i (
        .pixel_clk_in(pixel_clk_in),
        .reset       (reset),
        .time_left   (time_left),
        .point_total (point_total),
        .pixel       (pixel),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .hcount_out  (hcount_out),
        .vcount_out  (vcount_out)
    );

    initial pixel_clk_in = 1'b0;
    always #CLK_HALF pixel_clk_in = ~pixel_clk_in;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("ERROR: %s is %h, expected %h at %0t ns", name, actual, expected, $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic stop_on_problem(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic load_golden();
        int               fd;
        int               code;
        int               a;
        int               b;
        int               c;
        logic [8*16-1:0]  token;
        logic [8*256-1:0] rest;
        fd = $fopen("test/hud_golden.txt", "r");
        if (fd == 0) stop_on_problem("the golden file test/hud_golden.txt could not be opened");
        code = $fscanf(fd, " %s", token);
        while (code == 1) begin
            if (token == "#") begin
                code = $fgets(rest, fd);  // comment lines carry no data.
            end else if (token == "F" || token == "S") begin
                c = 0;
                if (token == "F") code = $fscanf(fd, " %h %h", a, b) + 1;
                else code = $fscanf(fd, " %d %d %h", a, b, c);
                if (code != 3) stop_on_problem("a line of the golden file is malformed");
                rec_is_frame.push_back(token == "F");
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_c.push_back(c);
            end else begin
                stop_on_problem("the golden file holds a record of unknown kind");
            end
            code = $fscanf(fd, " %s", token);
        end
        $fclose(fd);
    endtask

    task automatic wait_position(input int h, input int v);
        do begin
            @(negedge pixel_clk_in);
        end while (!(hcount_out == hcount_t'(h) && vcount_out == vcount_t'(v)));
    endtask

    task automatic drive_filler();
        time_left   = bcd3_t'($urandom);
        point_total = bcd3_t'($urandom);
    endtask

    task automatic apply_counters(input int t, input int p);
        if (applied > 0) begin
            wait_position(0, FILLER_LINE);
            drive_filler();  // the next value replaces it before any latch.
        end
        wait_position(0, APPLY_LINE);
        time_left   = bcd3_t'(t);
        point_total = bcd3_t'(p);
        applied++;
    endtask

    task automatic check_sync_timing();
        logic vs_prev;
        logic hs_prev;
        int   pulses;
        int   width;
        bit   done;
        pulses  = 0;
        width   = 0;
        done    = 1'b0;
        vs_prev = 1'b1;
        do begin
            @(negedge pixel_clk_in);
            done    = !vs_prev && vsync_out;
            vs_prev = vsync_out;
        end while (!done);
        hs_prev = hsync_out;
        done    = 1'b0;
        while (!done) begin
            @(negedge pixel_clk_in);
            if (hsync_out) width++;
            if (!hs_prev && hsync_out) pulses++;
            if (hs_prev && !hsync_out) begin
                check_value("hsync_out width", width, HSYNC_WIDTH);
                width = 0;
            end
            done    = !vs_prev && vsync_out;
            hs_prev = hsync_out;
            vs_prev = vsync_out;
        end
        check_value("hsync_out pulses per frame", pulses, V_TOTAL);
    endtask

    initial begin
        int unsigned seed;
        int          frames;
        reset       = 1'b1;
        time_left   = '0;
        point_total = '0;
        frames      = 0;
        seed        = $urandom(32'h9873cbea);
        load_golden();
        foreach (rec_is_frame[i]) frames += rec_is_frame[i];
        budget_cycles = longint'(frames + 2) * H_TOTAL * V_TOTAL;
        for (int i = 0; i < RESET_CYCLES + OUT_LATENCY; i++) begin
            @(negedge pixel_clk_in);
            check_value("pixel", pixel, BG_COLOUR);
            check_value("hsync_out", hsync_out, 1'b0);
            check_value("vsync_out", vsync_out, 1'b0);
            check_value("hcount_out", hcount_out, 0);
            check_value("vcount_out", vcount_out, 0);
            if (i == RESET_CYCLES - 1) begin
                reset = 1'b0;
                drive_filler();
            end
        end
        foreach (rec_is_frame[i]) begin
            if (rec_is_frame[i]) begin
                apply_counters(rec_a[i], rec_b[i]);
            end else begin
                wait_position(rec_a[i], rec_b[i]);
                check_value($sformatf("pixel at %0d,%0d", rec_a[i], rec_b[i]), pixel, rec_c[i]);
            end
        end
        check_sync_timing();
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "checks failed");
        end
    end

    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge pixel_clk_in);
        $display("TIMEOUT: the golden samples were never reached within %0d cycles",
                 budget_cycles);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule
